/* all.f */
hw/if_pkg.sv
hw/if_pc_sel.sv
hw/if_fetch_addr_cnt.sv
hw/if_fetch_fsm.sv
hw/if_id_reg.sv
hw/if_stage.sv
verif/tb_clk_gen.sv
verif/tb_if_stage.sv

/* Bender.yml */
package:
  name: if_stage

sources:
  # fetch stage rtl, package first
  - hw/if_pkg.sv
  - hw/if_pc_sel.sv
  - hw/if_fetch_addr_cnt.sv
  - hw/if_fetch_fsm.sv
  - hw/if_id_reg.sv
  - hw/if_stage.sv

  # testbench, top module tb_if_stage
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_if_stage.sv

/* verif/tb_if_stage.sv */
//////////////////////////////////////////////////
// fetch stage testbench
// random bus latencies, id stalls and redirects,
// checked against a pc and memory reference model
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_if_stage;
  import if_pkg::*;

  localparam int     CLK_PERIOD  = 40;
  localparam int     TEST_CYCLES = 1500;
  localparam addr_t  BOOT_ADDR   = 32'h0000_2000;
  localparam instr_t DATA_PAT    = 32'h5A5A_C3C3;

  logic        clk;
  logic        rst_n;
  // dut inputs
  logic        req;
  logic        pc_set;
  pc_sel_e     pc_mux;
  exc_pc_sel_e exc_pc_mux;
  exc_cause_t  exc_cause;
  addr_t       boot_addr;
  addr_t       branch_target;
  addr_t       mepc;
  addr_t       depc;
  addr_t       mtvec;
  logic        id_in_ready;
  logic        valid_clear;
  logic        instr_gnt;
  logic        instr_rvalid;
  instr_t      instr_rdata;
  logic        instr_err;
  // dut outputs
  logic        instr_req;
  addr_t       instr_addr;
  logic        instr_valid_id;
  logic        instr_new_id;
  instr_t      instr_rdata_id;
  logic        instr_fetch_err;
  addr_t       pc_id;
  addr_t       pc_if;
  logic        mtvec_init;
  logic        pc_mismatch;
  logic        if_busy;

  // scoreboard
  integer      seed = 32'h08bcd714;
  int          num_errors = 0;
  int          num_checks = 0;
  int          num_instr = 0;
  int          num_err_fetch = 0;
  addr_t       exp_pc;
  logic        pc_known;
  logic        exp_valid;
  logic        prev_clear;
  // bus model with at most one word in flight
  logic        in_flight;
  int          gnt_wait;
  int          rsp_wait;
  addr_t       pend_addr;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  if_stage dut0 (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .req_i              (req),
    .boot_addr_i        (boot_addr),
    .pc_set_i           (pc_set),
    .pc_mux_i           (pc_mux),
    .exc_pc_mux_i       (exc_pc_mux),
    .exc_cause_i        (exc_cause),
    .branch_target_ex_i (branch_target),
    .csr_mepc_i         (mepc),
    .csr_depc_i         (depc),
    .csr_mtvec_i        (mtvec),
    .id_in_ready_i      (id_in_ready),
    .instr_valid_clear_i(valid_clear),
    .instr_req_o        (instr_req),
    .instr_addr_o       (instr_addr),
    .instr_gnt_i        (instr_gnt),
    .instr_rvalid_i     (instr_rvalid),
    .instr_rdata_i      (instr_rdata),
    .instr_err_i        (instr_err),
    .instr_valid_id_o   (instr_valid_id),
    .instr_new_id_o     (instr_new_id),
    .instr_rdata_id_o   (instr_rdata_id),
    .instr_fetch_err_o  (instr_fetch_err),
    .pc_id_o            (pc_id),
    .pc_if_o            (pc_if),
    .csr_mtvec_init_o   (mtvec_init),
    .pc_mismatch_alert_o(pc_mismatch),
    .if_busy_o          (if_busy)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    num_checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h expected %h", name, got, exp);
      num_errors++;
    end
  endtask

  // next pc for the selector and csr values currently driven
  function automatic addr_t expected_next_pc();
    addr_t base;
    base = {mtvec[31:8], 8'h00};
    case (pc_mux)
      PC_JUMP: return branch_target;
      PC_ERET: return mepc;
      PC_DRET: return depc;
      PC_EXC: begin
        case (exc_pc_mux)
          EXC_PC_IRQ:     return base + {exc_cause[4:0], 2'b00};
          EXC_PC_DBD:     return 32'h1A11_0800;
          EXC_PC_DBG_EXC: return 32'h1A11_0808;
          default:        return base;
        endcase
      end
      default: return {boot_addr[31:8], 8'h00};
    endcase
  endfunction

  // one-cycle pc set with the target in the csr the selector reads
  task automatic redirect(input pc_sel_e mux, input exc_pc_sel_e exc_mux,
                          input exc_cause_t cause, input addr_t target);
    @(posedge clk);
    pc_set     <= 1'b1;
    pc_mux     <= mux;
    exc_pc_mux <= exc_mux;
    exc_cause  <= cause;
    case (mux)
      PC_JUMP: branch_target <= target;
      PC_ERET: mepc <= target;
      PC_DRET: depc <= target;
      PC_EXC:  mtvec <= target;
      default: boot_addr <= BOOT_ADDR;
    endcase
    @(posedge clk);
    pc_set <= 1'b0;
  endtask

  task automatic wait_instr(input int count);
    int goal;
    goal = num_instr + count;
    while (num_instr < goal) begin
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // per-cycle checks, bus model, id side
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n) begin
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
      id_in_ready  <= 1'b0;
      valid_clear  <= 1'b0;
      in_flight  = 1'b0;
      gnt_wait   = 0;
      exp_valid  = 1'b0;
      prev_clear = 1'b0;
      pc_known   = 1'b0;
    end else begin
      // values seen here belong to the cycle that just ended
      check_value("csr_mtvec_init_o", mtvec_init, pc_set && pc_mux == PC_BOOT);
      check_value("pc_mismatch_alert_o", pc_mismatch, 1'b0);
      if (instr_req) begin
        check_value("instr_addr_o[1:0]", instr_addr[1:0], 2'b00);
      end
      // the bus only answers while a fetch is outstanding
      if (instr_rvalid) begin
        check_value("if_busy_o", if_busy, 1'b1);
      end
      // valid rises with a new word and falls the cycle after a clear
      exp_valid  = instr_new_id | (exp_valid & ~prev_clear);
      prev_clear = valid_clear;
      check_value("instr_valid_id_o", instr_valid_id, exp_valid);
      if (instr_new_id) begin
        assert (pc_known) else begin
          $display("an instruction reached id before the first pc set");
          num_errors++;
        end
        check_value("pc_id_o", pc_id, exp_pc);
        check_value("instr_rdata_id_o", instr_rdata_id, exp_pc ^ DATA_PAT);
        check_value("instr_fetch_err_o", instr_fetch_err, &exp_pc[9:2]);
        // fetch side has already moved on to the following word
        check_value("pc_if_o", pc_if, exp_pc + 32'd4);
        if (&exp_pc[9:2]) begin
          num_err_fetch++;
        end
        exp_pc = exp_pc + 32'd4;
        num_instr++;
      end
      // a redirect only affects words accepted after it
      if (pc_set) begin
        exp_pc   = expected_next_pc();
        pc_known = 1'b1;
      end

      // gnt acts as a ready flag and the transfer happens when req meets it
      instr_rvalid <= 1'b0;
      if (instr_req && instr_gnt) begin
        pend_addr = instr_addr;
        in_flight = 1'b1;
        rsp_wait  = {$random(seed)} % 3;
        gnt_wait  = {$random(seed)} % 4;
        instr_gnt <= 1'b0;
      end else if (!instr_gnt) begin
        if (gnt_wait == 0) begin
          instr_gnt <= 1'b1;
        end else begin
          gnt_wait--;
        end
      end
      // memory data and error follow from the granted address
      if (in_flight) begin
        if (rsp_wait == 0) begin
          instr_rvalid <= 1'b1;
          instr_rdata  <= pend_addr ^ DATA_PAT;
          instr_err    <= &pend_addr[9:2];
          in_flight = 1'b0;
        end else begin
          rsp_wait--;
        end
      end

      // id stalls about a third of the time
      id_in_ready <= ({$random(seed)} % 3) != 0;
      valid_clear <= ({$random(seed)} % 4) == 0;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin : sequencer
    int          gap;
    int          sel;
    int          wait_n;
    addr_t       target;
    pc_sel_e     mux;
    exc_cause_t  cause;
    req           = 1'b0;
    pc_set        = 1'b0;
    pc_mux        = PC_BOOT;
    exc_pc_mux    = EXC_PC_EXC;
    exc_cause     = '0;
    boot_addr     = BOOT_ADDR;
    branch_target = '0;
    mepc          = '0;
    depc          = '0;
    mtvec         = 32'h0000_4000;
    id_in_ready   = 1'b0;
    valid_clear   = 1'b0;
    instr_gnt     = 1'b0;
    instr_rvalid  = 1'b0;
    instr_rdata   = '0;
    instr_err     = 1'b0;

    wait (rst_n === 1'b1);
    @(negedge clk);
    // quiet straight out of reset
    check_value("instr_req_o", instr_req, 1'b0);
    check_value("instr_new_id_o", instr_new_id, 1'b0);
    check_value("if_busy_o", if_busy, 1'b0);

    // boot and a run of sequential words
    redirect(PC_BOOT, EXC_PC_EXC, '0, BOOT_ADDR);
    req <= 1'b1;
    wait_instr(40);

    // redirects at random points cancel fetches in flight
    repeat (40) begin
      @(negedge clk);
      gap    = {$random(seed)} % 12;
      sel    = {$random(seed)} % 3;
      wait_n = {$random(seed)} % 4;
      target = $random(seed) & 32'hFFFF_FFFC;
      // about half land a few words below an error word
      if (target[4]) begin
        target[9:4] = 6'h3F;
        wait_n      = 4;
      end
      case (sel)
        0:       mux = PC_JUMP;
        1:       mux = PC_ERET;
        default: mux = PC_DRET;
      endcase
      repeat (gap) @(posedge clk);
      redirect(mux, EXC_PC_EXC, '0, target);
      wait_instr(wait_n);
    end

    // trap entry through every handler source
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      target = $random(seed);
      cause  = {1'b1, 5'($random(seed))};
      redirect(PC_EXC, exc_pc_sel_e'(i % 4), cause, target);
      wait_instr(3);
    end

    repeat (5) @(negedge clk);
    assert (num_instr >= 100) else begin
      $display("only %0d instructions reached id", num_instr);
      num_errors++;
    end
    assert (num_err_fetch > 0) else begin
      $display("no fetch with a bus error reached id");
      num_errors++;
    end
    $display("checks %0d, errors %0d, instructions %0d", num_checks, num_errors, num_instr);
    if (num_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // upper bound of the whole sequence with a wide margin
  initial begin : watchdog
    #(TEST_CYCLES * CLK_PERIOD * 20);
    $display("watchdog expired before the sequence ended, checks %0d, errors %0d",
             num_checks, num_errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* verif/tb_clk_gen.sv */
//////////////////////////////////////////////////
// testbench clock and reset
// 40 ns clock, reset held low for 8 cycles
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // release on a rising edge like the rest of the stimulus
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* hw/if_stage.sv */
//////////////////////////////////////////////////
// instruction fetch stage top
// pc selection, fetch counter, bus fsm and if-id register
//////////////////////////////////////////////////

`timescale 1ns/1ps

module if_stage (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,
  input  if_pkg::addr_t        boot_addr_i,
  // pc control from the controller
  input  logic                 pc_set_i,
  input  if_pkg::pc_sel_e      pc_mux_i,
  input  if_pkg::exc_pc_sel_e  exc_pc_mux_i,
  input  if_pkg::exc_cause_t   exc_cause_i,
  input  if_pkg::addr_t        branch_target_ex_i,
  input  if_pkg::addr_t        csr_mepc_i,
  input  if_pkg::addr_t        csr_depc_i,
  input  if_pkg::addr_t        csr_mtvec_i,
  // id handshake
  input  logic                 id_in_ready_i,
  input  logic                 instr_valid_clear_i,
  // instruction bus
  output logic                 instr_req_o,
  output if_pkg::addr_t        instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  if_pkg::instr_t       instr_rdata_i,
  input  logic                 instr_err_i,
  // if-id outputs
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output if_pkg::instr_t       instr_rdata_id_o,
  output logic                 instr_fetch_err_o,
  output if_pkg::addr_t        pc_id_o,
  // misc
  output if_pkg::addr_t        pc_if_o,
  output logic                 csr_mtvec_init_o,
  output logic                 pc_mismatch_alert_o,
  output logic                 if_busy_o
);
  import if_pkg::*;

  addr_t      fetch_addr_n;
  addr_t      fetch_addr;
  logic       fetch_valid;
  fetch_rsp_t fetch_rsp;
  logic       fetch_accept;

  if_pc_sel u_pc_sel (
    .pc_set_i          (pc_set_i),
    .pc_mux_i          (pc_mux_i),
    .exc_pc_mux_i      (exc_pc_mux_i),
    .exc_cause_i       (exc_cause_i),
    .boot_addr_i       (boot_addr_i),
    .branch_target_ex_i(branch_target_ex_i),
    .csr_mepc_i        (csr_mepc_i),
    .csr_depc_i        (csr_depc_i),
    .csr_mtvec_i       (csr_mtvec_i),
    .fetch_addr_n_o    (fetch_addr_n),
    .csr_mtvec_init_o  (csr_mtvec_init_o)
  );

  if_fetch_addr_cnt u_addr_cnt (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .pc_set_i      (pc_set_i),
    .fetch_addr_n_i(fetch_addr_n),
    .fetch_accept_i(fetch_accept),
    .fetch_addr_o  (fetch_addr)
  );

  if_fetch_fsm u_fetch_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .pc_set_i      (pc_set_i),
    .fetch_addr_i  (fetch_addr),
    .fetch_accept_i(fetch_accept),
    .instr_req_o   (instr_req_o),
    .instr_addr_o  (instr_addr_o),
    .instr_gnt_i   (instr_gnt_i),
    .instr_rvalid_i(instr_rvalid_i),
    .instr_rdata_i (instr_rdata_i),
    .instr_err_i   (instr_err_i),
    .fetch_valid_o (fetch_valid),
    .fetch_rsp_o   (fetch_rsp),
    .busy_o        (if_busy_o)
  );

  if_id_reg u_if_id (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .pc_set_i           (pc_set_i),
    .id_in_ready_i      (id_in_ready_i),
    .instr_valid_clear_i(instr_valid_clear_i),
    .fetch_valid_i      (fetch_valid),
    .fetch_rsp_i        (fetch_rsp),
    .fetch_accept_o     (fetch_accept),
    .instr_valid_id_o   (instr_valid_id_o),
    .instr_new_id_o     (instr_new_id_o),
    .instr_rdata_id_o   (instr_rdata_id_o),
    .instr_fetch_err_o  (instr_fetch_err_o),
    .pc_id_o            (pc_id_o),
    .pc_if_o            (pc_if_o),
    .pc_mismatch_alert_o(pc_mismatch_alert_o)
  );

endmodule

/* hw/if_id_reg.sv */
//////////////////////////////////////////////////
// if-id pipeline register
// accepts fetched words into id, keeps valid/new
// flags and checks sequential pc increments
//////////////////////////////////////////////////

`timescale 1ns/1ps

module if_id_reg (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                pc_set_i,
  input  logic                id_in_ready_i,
  input  logic                instr_valid_clear_i,
  // from the fetch fsm
  input  logic                fetch_valid_i,
  input  if_pkg::fetch_rsp_t  fetch_rsp_i,
  output logic                fetch_accept_o,
  // id side
  output logic                instr_valid_id_o,
  output logic                instr_new_id_o,
  output if_pkg::instr_t      instr_rdata_id_o,
  output logic                instr_fetch_err_o,
  output if_pkg::addr_t       pc_id_o,
  output if_pkg::addr_t       pc_if_o,
  output logic                pc_mismatch_alert_o
);
  import if_pkg::*;

  logic  valid_q, valid_d;
  logic  new_q;
  logic  seq_q, seq_d;
  addr_t pc_next_exp;

  // word moves into id when presented and id is ready
  assign fetch_accept_o = fetch_valid_i & id_in_ready_i;

  // pc of the word currently presented by the fetch fsm
  assign pc_if_o = fetch_rsp_i.addr;

  //////////////////////////////////////////////////
  // valid and new flags
  //////////////////////////////////////////////////

  // valid holds until the controller clears it
  assign valid_d = (fetch_accept_o & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one cycle marker after each accepting edge
      new_q   <= fetch_accept_o;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // data side, loaded on acceptance only
  always_ff @(posedge clk_i) begin
    if (fetch_accept_o) begin
      instr_rdata_id_o  <= fetch_rsp_i.rdata;
      instr_fetch_err_o <= fetch_rsp_i.err;
      pc_id_o           <= fetch_rsp_i.addr;
    end
  end

  //////////////////////////////////////////////////
  // sequential pc check
  //////////////////////////////////////////////////

  // no check across redirects, after bus errors or before the first word
  assign seq_d = (seq_q | fetch_accept_o) & ~pc_set_i & ~(fetch_valid_i & fetch_rsp_i.err);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_next_exp         = pc_id_o + INSTR_BYTES;
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (fetch_rsp_i.addr != pc_next_exp);

  // new word in id is valid unless cleared the same cycle
  new_implies_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_valid_id_o || instr_valid_clear_i);

endmodule

/* hw/if_fetch_fsm.sv */
//////////////////////////////////////////////////
// fetch bus fsm
// one outstanding req/gnt/rvalid transfer, a one
// word hold register and dropping of cancelled words
//////////////////////////////////////////////////

`timescale 1ns/1ps

module if_fetch_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_i,
  input  logic                pc_set_i,
  input  if_pkg::addr_t       fetch_addr_i,
  input  logic                fetch_accept_i,
  // instruction bus
  output logic                instr_req_o,
  output if_pkg::addr_t       instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  if_pkg::instr_t      instr_rdata_i,
  input  logic                instr_err_i,
  // towards the if-id register
  output logic                fetch_valid_o,
  output if_pkg::fetch_rsp_t  fetch_rsp_o,
  output logic                busy_o
);
  import if_pkg::*;

  fetch_state_e state_q, state_d;
  fetch_rsp_t   bus_rsp;
  fetch_rsp_t   hold_q;
  logic         hold_en;

  // counter holds the in-flight address until the word is accepted
  assign instr_addr_o = fetch_addr_i;

  assign bus_rsp.rdata = instr_rdata_i;
  assign bus_rsp.addr  = fetch_addr_i;
  assign bus_rsp.err   = instr_err_i;

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    instr_req_o = 1'b0;
    hold_en     = 1'b0;
    case (state_q)
      FETCH_IDLE: begin
        // a pc set withdraws any ungranted request
        instr_req_o = req_i & ~pc_set_i;
        if (req_i && !pc_set_i && instr_gnt_i) begin
          state_d = FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          if (pc_set_i || fetch_accept_i) begin
            state_d = FETCH_IDLE;
          end else begin
            // id stalled, park the word
            hold_en = 1'b1;
            state_d = FETCH_HOLD;
          end
        end else if (pc_set_i) begin
          // granted word still on its way, drop it later
          state_d = FETCH_FLUSH;
        end
      end
      FETCH_HOLD: begin
        if (pc_set_i || fetch_accept_i) begin
          state_d = FETCH_IDLE;
        end
      end
      FETCH_FLUSH: begin
        if (instr_rvalid_i) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // hold register, payload only
  always_ff @(posedge clk_i) begin
    if (hold_en) begin
      hold_q <= bus_rsp;
    end
  end

  //////////////////////////////////////////////////
  // outputs to the if-id register
  //////////////////////////////////////////////////

  // a word seen together with a pc set is stale
  assign fetch_valid_o = ~pc_set_i &
                         ((state_q == FETCH_WAIT && instr_rvalid_i) || state_q == FETCH_HOLD);
  assign fetch_rsp_o   = (state_q == FETCH_HOLD) ? hold_q : bus_rsp;
  assign busy_o        = (state_q != FETCH_IDLE);

  // request address comes from the pc mux through the counter
  req_addr_ok_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> !$isunknown(instr_addr_o) && instr_addr_o[1:0] == 2'b00);

  // bus must not answer without an outstanding grant
  no_rvalid_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == FETCH_IDLE |-> !instr_rvalid_i);

endmodule

/* hw/if_fetch_addr_cnt.sv */
//////////////////////////////////////////////////
// fetch address counter
// next word to fetch, reloaded on a pc set and
// stepped by one word per accepted instruction
//////////////////////////////////////////////////

`timescale 1ns/1ps

module if_fetch_addr_cnt (
  input  logic           clk_i,
  input  logic           rst_ni,
  // redirect
  input  logic           pc_set_i,
  input  if_pkg::addr_t  fetch_addr_n_i,
  // id took the current word
  input  logic           fetch_accept_i,
  output if_pkg::addr_t  fetch_addr_o
);
  import if_pkg::*;

  addr_t fetch_addr_q;
  addr_t fetch_addr_d;

  // redirect wins over the sequential step
  always_comb begin
    fetch_addr_d = fetch_addr_q;
    if (pc_set_i) begin
      fetch_addr_d = fetch_addr_n_i;
    end else if (fetch_accept_i) begin
      fetch_addr_d = fetch_addr_q + INSTR_BYTES;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
    end else begin
      fetch_addr_q <= fetch_addr_d;
    end
  end

  // also the address held on the bus and in the response
  assign fetch_addr_o = fetch_addr_q;

  // jump targets and csr returns must keep word alignment
  fetch_addr_aligned_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_addr_q[1:0] == 2'b00);

endmodule

/* hw/if_pc_sel.sv */
//////////////////////////////////////////////////
// next pc selection
// picks the handler address and the next fetch pc,
// flags mtvec init on boot
//////////////////////////////////////////////////

`timescale 1ns/1ps

module if_pc_sel (
  input  logic                 pc_set_i,
  input  if_pkg::pc_sel_e      pc_mux_i,
  input  if_pkg::exc_pc_sel_e  exc_pc_mux_i,
  input  if_pkg::exc_cause_t   exc_cause_i,
  input  if_pkg::addr_t        boot_addr_i,
  input  if_pkg::addr_t        branch_target_ex_i,
  input  if_pkg::addr_t        csr_mepc_i,
  input  if_pkg::addr_t        csr_depc_i,
  input  if_pkg::addr_t        csr_mtvec_i,
  output if_pkg::addr_t        fetch_addr_n_o,
  output logic                 csr_mtvec_init_o
);
  import if_pkg::*;

  addr_t   boot_base;
  addr_t   mtvec_base;
  addr_t   exc_pc;
  irq_id_t irq_id;

  // low bits of both bases are ignored
  assign boot_base  = {boot_addr_i[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
  assign mtvec_base = {csr_mtvec_i[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};

  // the irq selector already implies an interrupt, so only the id bits matter
  assign irq_id = exc_cause_i[4:0];

  //////////////////////////////////////////////////
  // handler address
  //////////////////////////////////////////////////

  always_comb begin
    case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      // one word per vector entry
      EXC_PC_IRQ:     exc_pc = mtvec_base + addr_t'({irq_id, 2'b00});
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = mtvec_base;
    endcase
  end

  //////////////////////////////////////////////////
  // next fetch pc
  //////////////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = boot_base;
      PC_JUMP: fetch_addr_n_o = branch_target_ex_i;
      // trap entry
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap and from debug
      PC_ERET: fetch_addr_n_o = csr_mepc_i;
      PC_DRET: fetch_addr_n_o = csr_depc_i;
      // unknown selector restarts at boot
      default: fetch_addr_n_o = boot_base;
    endcase
  end

  // csr file loads mtvec from the boot address
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  // boot base must sit on a 256 byte boundary
  boot_addr_aligned_a: assert final (
    $isunknown(boot_addr_i) || boot_addr_i[VEC_ALIGN_BITS-1:0] == '0
  ) else $error("boot address not aligned: %h", boot_addr_i);

  // controller only requests known pc sources
  pc_mux_known_a: assert final (
    pc_set_i !== 1'b1 || pc_mux_i inside {PC_BOOT, PC_JUMP, PC_EXC, PC_ERET, PC_DRET}
  ) else $error("unknown pc selector: %h", pc_mux_i);

endmodule

/* hw/if_pkg.sv */
//////////////////////////////////////////////////
// instruction fetch stage package
// widths, debug entry points, selector enums and
// the fetched-word struct shared by the fetch stage
//////////////////////////////////////////////////

package if_pkg;

  //////////////////////////////////////////////////
  // widths with a meaning
  //////////////////////////////////////////////////

  // byte address
  typedef logic [31:0] addr_t;
  // one instruction word
  typedef logic [31:0] instr_t;
  // interrupt number
  typedef logic [4:0]  irq_id_t;
  // exception cause, msb flags an interrupt, low bits carry the irq id
  typedef logic [5:0]  exc_cause_t;

  //////////////////////////////////////////////////
  // selectors and states
  //////////////////////////////////////////////////

  // next pc source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // handler address source
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // bus fetch fsm
  typedef enum logic [1:0] {
    FETCH_IDLE  = 2'd0,
    FETCH_WAIT  = 2'd1,
    FETCH_HOLD  = 2'd2,
    FETCH_FLUSH = 2'd3
  } fetch_state_e;

  // one fetched word with its address and bus error
  typedef struct packed {
    instr_t rdata;
    addr_t  addr;
    logic   err;
  } fetch_rsp_t;

  //////////////////////////////////////////////////
  // constants
  //////////////////////////////////////////////////

  // debug module entry points
  localparam addr_t DM_HALT_ADDR = 32'h1A11_0800;
  localparam addr_t DM_EXC_ADDR  = 32'h1A11_0808;

  // boot and mtvec bases are 256 byte aligned
  localparam int unsigned VEC_ALIGN_BITS = 8;

  // every instruction is one aligned word
  localparam addr_t INSTR_BYTES = 32'd4;

endpackage
